//--- credit_pkg.sv
package credit_pkg;

    // router geometry
    localparam int NUM_VC   = 4;                 // vcs per port
    localparam int NUM_PORT = 5;                 // router ports
    localparam int NUM_OVC  = NUM_PORT * NUM_VC; // output vcs over all ports

    // one-hot vc select inside a port
    typedef logic [NUM_VC-1:0] vc_onehot_t;

    // one-hot destination among the other ports with the own port squeezed out
    // ports below the source keep their index and ports above shift down by one
    typedef logic [NUM_PORT-2:0] dest_port_t;

    // one bit per ovc at index port * NUM_VC + vc
    typedef logic [NUM_OVC-1:0] ovc_vector_t;

    // state of one input vc as seen by the credit logic
    typedef struct packed {
        vc_onehot_t assigned_ovc; // ovc given by the vc allocator
        dest_port_t dest_port;    // routed output port
        logic       flit_is_tail; // head-of-queue flit is a tail
    } ivc_info_t;

    // switch grant of one input port
    typedef struct packed {
        vc_onehot_t granted_ivc;       // zero when the port has no grant
        dest_port_t granted_dest_port; // output port the flit goes to
    } port_grant_t;

    // registered buffer flags of all ovcs
    typedef struct packed {
        ovc_vector_t full;        // no credit left
        ovc_vector_t nearly_full; // one credit or less
    } ovc_flags_t;

endpackage

//--- inport_credit_decoder.sv
`timescale 1ns/1ps

// Converts the switch grant of one input port into per-ovc events.
// Vectors are laid out slot-major with bit = slot * NUM_VC + vc, where slot
// is the destination port with the own port removed.
module inport_credit_decoder (
    input  credit_pkg::ivc_info_t   ivc_info [credit_pkg::NUM_VC],
    input  credit_pkg::port_grant_t grant,
    output logic [credit_pkg::NUM_VC*(credit_pkg::NUM_PORT-1)-1:0] credit_decreased,
    output logic [credit_pkg::NUM_VC*(credit_pkg::NUM_PORT-1)-1:0] ovc_released
);
    import credit_pkg::*;

    localparam int SLOTS = NUM_PORT - 1;

    vc_onehot_t granted_ovc;  // ovc of the winning input vc
    logic       granted_tail; // winning flit closes its packet

    // one-hot mux over the input vcs of this port
    always_comb begin
        granted_ovc  = '0;
        granted_tail = 1'b0;
        for (int v = 0; v < NUM_VC; v++) begin
            if (grant.granted_ivc[v]) begin
                granted_ovc  = granted_ovc | ivc_info[v].assigned_ovc;
                granted_tail = granted_tail | ivc_info[v].flit_is_tail;
            end
        end
    end

    // spread the selected ovc onto the granted destination slot
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            if (grant.granted_dest_port[s]) begin
                credit_decreased[s*NUM_VC +: NUM_VC] = granted_ovc;
            end else begin
                credit_decreased[s*NUM_VC +: NUM_VC] = '0;
            end
        end
    end

    // a tail flit frees the ovc it leaves through
    assign ovc_released = granted_tail ? credit_decreased : '0;

endmodule

//--- ovc_credit_tracker.sv
`timescale 1ns/1ps

// Credit bookkeeping for every output vc of the router.
// A counter holds the free slots of the downstream buffer; it starts at
// BUFFER_DEPTH-1 and the flags are taken from the next count so they
// line up with the counter after the clock edge.
module ovc_credit_tracker #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  credit_pkg::ovc_vector_t credit_increased,
    input  credit_pkg::ovc_vector_t credit_decreased,
    input  credit_pkg::ovc_vector_t ovc_allocated,
    input  credit_pkg::ovc_vector_t ovc_released,
    output credit_pkg::ovc_flags_t  flags,
    output credit_pkg::ovc_vector_t ovc_available
);
    import credit_pkg::*;

    localparam int CNT_W = (BUFFER_DEPTH > 2) ? $clog2(BUFFER_DEPTH) : 1;
    localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(BUFFER_DEPTH - 1);

    logic [CNT_W-1:0] count      [NUM_OVC]; // free slots per ovc
    logic [CNT_W-1:0] count_next [NUM_OVC];
    ovc_flags_t       flags_next;
    ovc_vector_t      status;               // ovc owned by some input vc

    // up/down counter where simultaneous inc and dec cancel out
    always_comb begin
        for (int i = 0; i < NUM_OVC; i++) begin
            count_next[i] = count[i];
            if (credit_increased[i] && !credit_decreased[i]) begin
                count_next[i] = count[i] + CNT_W'(1);
            end else if (!credit_increased[i] && credit_decreased[i]) begin
                count_next[i] = count[i] - CNT_W'(1);
            end
        end
    end

    // flags follow the next count
    always_comb begin
        flags_next = '0;
        for (int i = 0; i < NUM_OVC; i++) begin
            flags_next.full[i]        = (count_next[i] == '0);
            flags_next.nearly_full[i] = (count_next[i] <= CNT_W'(1));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_OVC; i++) begin
                count[i] <= CNT_INIT; // downstream buffers start empty
            end
        end else begin
            for (int i = 0; i < NUM_OVC; i++) begin
                count[i] <= count_next[i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else begin
            flags <= flags_next;
        end
    end

    // allocation overrides a release in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            status <= '0;
        end else begin
            status <= (status & ~ovc_released) | ovc_allocated;
        end
    end

    // non-atomic reuse lets a free ovc still hold flits of an old packet
    // as long as it has room for more than one flit
    assign ovc_available = ~(status | flags.nearly_full);

endmodule

//--- assigned_ovc_full_mask.sv
`timescale 1ns/1ps

// Per input vc flag that tells the switch allocator whether the ovc
// this vc was given is out of room. The vectors come without the own port.
module assigned_ovc_full_mask (
    input  logic                  clk,
    input  logic                  reset,
    input  credit_pkg::ivc_info_t info,
    input  logic                  ivc_sw_grant,
    input  logic [credit_pkg::NUM_VC*(credit_pkg::NUM_PORT-1)-1:0] full,
    input  logic [credit_pkg::NUM_VC*(credit_pkg::NUM_PORT-1)-1:0] nearly_full,
    input  logic [credit_pkg::NUM_VC*(credit_pkg::NUM_PORT-1)-1:0] credit_in,
    output logic                  assigned_ovc_not_full
);
    import credit_pkg::*;

    localparam int SLOTS  = NUM_PORT - 1;
    localparam int SLOT_W = NUM_VC * SLOTS;

    logic [SLOT_W-1:0] full_masked;        // credit coming back clears it
    logic [SLOT_W-1:0] nearly_full_masked;
    vc_onehot_t        full_group;         // flags of the destination port
    vc_onehot_t        nearly_full_group;
    logic              full_sel;
    logic              nearly_full_sel;
    logic              full_reg;
    logic              nearly_full_reg;

    assign full_masked        = full & ~credit_in;
    assign nearly_full_masked = nearly_full & ~credit_in;

    // pick the group of the routed output port
    always_comb begin
        full_group        = '0;
        nearly_full_group = '0;
        for (int s = 0; s < SLOTS; s++) begin
            if (info.dest_port[s]) begin
                full_group        = full_group | full_masked[s*NUM_VC +: NUM_VC];
                nearly_full_group = nearly_full_group | nearly_full_masked[s*NUM_VC +: NUM_VC];
            end
        end
    end

    // then the assigned vc within it
    assign full_sel        = |(full_group & info.assigned_ovc);
    assign nearly_full_sel = |(nearly_full_group & info.assigned_ovc);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            full_reg        <= 1'b0;
            nearly_full_reg <= 1'b0;
        end else begin
            full_reg        <= full_sel;
            // the flit now being switched takes the last slot
            nearly_full_reg <= nearly_full_sel & ivc_sw_grant;
        end
    end

    assign assigned_ovc_not_full = ~(full_reg | nearly_full_reg);

endmodule

//--- credit_counter_top.sv
`timescale 1ns/1ps

module credit_counter_top #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  credit_pkg::ivc_info_t   ivc_info [credit_pkg::NUM_OVC],
    input  credit_pkg::port_grant_t port_grant [credit_pkg::NUM_PORT],
    input  credit_pkg::ovc_vector_t ovc_allocated,
    input  credit_pkg::ovc_vector_t credit_in,
    input  credit_pkg::ovc_vector_t ivc_sw_grant,
    output credit_pkg::ovc_vector_t ovc_available,
    output credit_pkg::ovc_vector_t assigned_ovc_not_full
);
    import credit_pkg::*;

    localparam int SLOTS  = NUM_PORT - 1;
    localparam int SLOT_W = NUM_VC * SLOTS;

    logic [SLOT_W-1:0] port_decreased    [NUM_PORT]; // slot-major decoder outputs
    logic [SLOT_W-1:0] port_released     [NUM_PORT];
    logic [SLOT_W-1:0] full_other        [NUM_PORT]; // own port removed
    logic [SLOT_W-1:0] nearly_full_other [NUM_PORT];
    logic [SLOT_W-1:0] credit_other      [NUM_PORT];
    ovc_vector_t       credit_decreased;
    ovc_vector_t       ovc_released;
    ovc_flags_t        flags;

    // squeeze the ovcs of port p out of a full ovc vector
    function automatic logic [SLOT_W-1:0] drop_port(input ovc_vector_t vec, input int p);
        logic [SLOT_W-1:0] res;
        res = '0;
        for (int o = 0; o < NUM_OVC; o++) begin
            if (o / NUM_VC < p) begin
                res[o] = vec[o];
            end else if (o / NUM_VC > p) begin
                res[o-NUM_VC] = vec[o];
            end
        end
        return res;
    endfunction

    for (genvar p = 0; p < NUM_PORT; p++) begin : g_port
        ivc_info_t port_info [NUM_VC];

        for (genvar v = 0; v < NUM_VC; v++) begin : g_vc
            assign port_info[v] = ivc_info[p*NUM_VC + v];
        end

        inport_credit_decoder u_decoder (
            .ivc_info         (port_info),
            .grant            (port_grant[p]),
            .credit_decreased (port_decreased[p]),
            .ovc_released     (port_released[p])
        );

        assign full_other[p]        = drop_port(flags.full, p);
        assign nearly_full_other[p] = drop_port(flags.nearly_full, p);
        assign credit_other[p]      = drop_port(credit_in, p);
    end

    // collect the events of every source port per destination ovc
    for (genvar o = 0; o < NUM_OVC; o++) begin : g_ovc
        logic [SLOTS-1:0] dec_src; // one bit per source port
        logic [SLOTS-1:0] rel_src;

        for (genvar sp = 0; sp < NUM_PORT; sp++) begin : g_src
            if (sp < o / NUM_VC) begin : g_below
                // destination above the source shifts down one slot
                assign dec_src[sp] = port_decreased[sp][o-NUM_VC];
                assign rel_src[sp] = port_released[sp][o-NUM_VC];
            end else if (sp > o / NUM_VC) begin : g_above
                assign dec_src[sp-1] = port_decreased[sp][o];
                assign rel_src[sp-1] = port_released[sp][o];
            end
        end

        assign credit_decreased[o] = (|dec_src) | ovc_allocated[o]; // header takes a credit too
        assign ovc_released[o]     = |rel_src;
    end

    ovc_credit_tracker #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_tracker (
        .clk              (clk),
        .reset            (reset),
        .credit_increased (credit_in),
        .credit_decreased (credit_decreased),
        .ovc_allocated    (ovc_allocated),
        .ovc_released     (ovc_released),
        .flags            (flags),
        .ovc_available    (ovc_available)
    );

    for (genvar i = 0; i < NUM_OVC; i++) begin : g_ivc
        assigned_ovc_full_mask u_mask (
            .clk                   (clk),
            .reset                 (reset),
            .info                  (ivc_info[i]),
            .ivc_sw_grant          (ivc_sw_grant[i]),
            .full                  (full_other[i/NUM_VC]),
            .nearly_full           (nearly_full_other[i/NUM_VC]),
            .credit_in             (credit_other[i/NUM_VC]),
            .assigned_ovc_not_full (assigned_ovc_not_full[i])
        );
    end

endmodule

//--- credit_counter_tb.sv
`timescale 1ns/1ps

module credit_counter_tb;
    import credit_pkg::*;

    localparam int BUFFER_DEPTH = 4;
    localparam int NAME_W       = 8 * 32;

    // one line of the test file
    typedef struct packed {
        logic [NAME_W-1:0] name;
        logic [7:0]        ivc;           // input vc that gets the info
        ivc_info_t         info;
        logic [7:0]        port;          // input port that gets the grant
        port_grant_t       grant;
        ovc_vector_t       allocated;
        ovc_vector_t       credit;
        ovc_vector_t       sw_grant;
        ovc_vector_t       exp_available;
        ovc_vector_t       exp_not_full;
    } test_step_t;

    logic        clk;
    logic        reset;
    ivc_info_t   ivc_info [NUM_OVC];
    port_grant_t port_grant [NUM_PORT];
    ovc_vector_t ovc_allocated;
    ovc_vector_t credit_in;
    ovc_vector_t ivc_sw_grant;
    ovc_vector_t ovc_available;
    ovc_vector_t assigned_ovc_not_full;

    test_step_t steps [$];
    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;
    int         max_cycles  = 0; // zero until the test file is read
    logic       file_ok;

    credit_counter_top #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) DUT (
        .clk                   (clk),
        .reset                 (reset),
        .ivc_info              (ivc_info),
        .port_grant            (port_grant),
        .ovc_allocated         (ovc_allocated),
        .credit_in             (credit_in),
        .ivc_sw_grant          (ivc_sw_grant),
        .ovc_available         (ovc_available),
        .assigned_ovc_not_full (assigned_ovc_not_full)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (max_cycles > 0 && cycle_count >= max_cycles) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", max_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input logic [NAME_W-1:0] test_name, input string what,
                               input ovc_vector_t expected, input ovc_vector_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error [%0s] %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    // clears the event pulses while input vc state and sw grant stay as they are
    task automatic drive_idle();
        for (int p = 0; p < NUM_PORT; p++) begin
            port_grant[p] = '0;
        end
        ovc_allocated = '0;
        credit_in     = '0;
    endtask

    task automatic clear_inputs();
        for (int i = 0; i < NUM_OVC; i++) begin
            ivc_info[i] = '0;
        end
        ivc_sw_grant = '0;
        drive_idle();
    endtask

    task automatic apply_step(input test_step_t st);
        clear_inputs();
        ivc_info[st.ivc]    = st.info;
        port_grant[st.port] = st.grant;
        ovc_allocated       = st.allocated;
        credit_in           = st.credit;
        ivc_sw_grant        = st.sw_grant;
    endtask

    // one cycle of events then two idle cycles to cover the mask latency
    task automatic run_step(input test_step_t st);
        apply_step(st);
        @(negedge clk);
        drive_idle();
        repeat (2) @(negedge clk);
        check_value(st.name, "ovc_available", st.exp_available, ovc_available);
        check_value(st.name, "assigned_ovc_not_full", st.exp_not_full, assigned_ovc_not_full);
    endtask

    task automatic read_tests();
        int                fd;
        int                rc;
        int                line_no;
        int                ivc_idx;
        int                port_idx;
        string             line;
        logic [NAME_W-1:0] name;
        logic [31:0]       assigned;
        logic [31:0]       dest;
        logic [31:0]       tail;
        logic [31:0]       givc;
        logic [31:0]       gdest;
        logic [31:0]       alloc;
        logic [31:0]       credit;
        logic [31:0]       sw;
        logic [31:0]       exp_av;
        logic [31:0]       exp_nf;
        test_step_t        st;
        line_no = 0;
        file_ok = 1'b0;
        fd = $fopen("credit_counter_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test file credit_counter_tests.txt");
        end else begin
            file_ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                line_no++;
                if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    rc = $sscanf(line, "%s %d %h %h %h %d %h %h %h %h %h %h %h",
                                 name, ivc_idx, assigned, dest, tail, port_idx, givc, gdest,
                                 alloc, credit, sw, exp_av, exp_nf);
                    if (rc != 13 || ivc_idx < 0 || ivc_idx >= NUM_OVC
                        || port_idx < 0 || port_idx >= NUM_PORT) begin
                        $display("Test file line %0d could not be parsed", line_no);
                        error_count++;
                    end else begin
                        st.name                    = name;
                        st.ivc                     = ivc_idx[7:0];
                        st.info.assigned_ovc       = assigned[NUM_VC-1:0];
                        st.info.dest_port          = dest[NUM_PORT-2:0];
                        st.info.flit_is_tail       = tail[0];
                        st.port                    = port_idx[7:0];
                        st.grant.granted_ivc       = givc[NUM_VC-1:0];
                        st.grant.granted_dest_port = gdest[NUM_PORT-2:0];
                        st.allocated               = alloc[NUM_OVC-1:0];
                        st.credit                  = credit[NUM_OVC-1:0];
                        st.sw_grant                = sw[NUM_OVC-1:0];
                        st.exp_available           = exp_av[NUM_OVC-1:0];
                        st.exp_not_full            = exp_nf[NUM_OVC-1:0];
                        steps.push_back(st);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        reset = 1'b1;
        clear_inputs();
        read_tests();
        max_cycles = steps.size() * 4 + 50;
        if (!file_ok) begin
            $display("Simulation failed");
            $finish;
        end else begin
            repeat (10) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            if (steps.size() == 0) begin
                $display("The test file holds no test steps");
                error_count++;
            end
            foreach (steps[i]) begin
                run_step(steps[i]);
            end
            $display("%0d checks done, %0d errors", check_count, error_count);
            if (error_count == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

//--- credit_counter_tests.txt
# name ivc assigned_ovc dest_port tail grant_port granted_ivc granted_dest alloc credit sw_grant exp_available exp_not_full
# ivc and grant_port are decimal, the rest hex; ivc info and sw_grant stay applied during the idle cycles
reset_state 0 0 0 0 0 0 0 00000 00000 00000 fffff fffff
alloc_2_1 0 2 2 0 0 0 0 00200 00000 00000 ffdff fffff
send_2_1_a 0 2 2 0 0 1 2 00000 00000 00000 ffdff fffff
nf_sw_grant 0 2 2 0 0 0 0 00000 00000 00001 ffdff ffffe
nf_no_grant 0 2 2 0 0 0 0 00000 00000 00000 ffdff fffff
send_2_1_full 0 2 2 0 0 1 2 00000 00000 00000 ffdff ffffe
send_with_credit 0 2 2 0 0 1 2 00000 00200 00000 ffdff ffffe
credit_2_1_a 0 2 2 0 0 0 0 00000 00200 00000 ffdff fffff
send_tail_2_1 0 2 2 1 0 1 2 00000 00000 00000 ffdff ffffe
credit_2_1_b 0 2 2 1 0 0 0 00000 00200 00000 ffdff fffff
credit_2_1_c 0 2 2 1 0 0 0 00000 00200 00000 fffff fffff
credit_2_1_d 0 2 2 1 0 0 0 00000 00200 00000 fffff fffff
p0_slot0_a 1 8 1 0 0 2 1 00000 00000 00000 fffff fffff
p0_slot0_b 1 8 1 0 0 2 1 00000 00000 00000 fff7f fffff
p0_credit_a 1 8 1 0 0 0 0 00000 00080 00000 fffff fffff
p0_credit_b 1 8 1 0 0 0 0 00000 00080 00000 fffff fffff
p3_slot3_a 12 1 8 0 3 1 8 00000 00000 00000 fffff fffff
p3_slot3_b 12 1 8 0 3 1 8 00000 00000 00000 effff fffff
p3_nf_sw_grant 12 1 8 0 3 0 0 00000 00000 01000 effff fefff
p3_slot3_full 12 1 8 0 3 1 8 00000 00000 00000 effff fefff
p3_credit_a 12 1 8 0 3 0 0 00000 10000 00000 effff fffff
p3_credit_b 12 1 8 0 3 0 0 00000 10000 00000 fffff fffff
p3_credit_c 12 1 8 0 3 0 0 00000 10000 00000 fffff fffff
alloc_and_release 13 4 4 1 3 2 4 00400 00000 00000 ffbff fffff
release_2_2 13 4 4 1 3 2 4 00000 00000 00000 ffbff fffff
credit_2_2_a 13 4 4 1 3 0 0 00000 00400 00000 fffff fffff
credit_2_2_b 13 4 4 1 3 0 0 00000 00400 00000 fffff fffff

//--- build.f
credit_pkg.sv
inport_credit_decoder.sv
ovc_credit_tracker.sv
assigned_ovc_full_mask.sv
credit_counter_top.sv
credit_counter_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the credit counter testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module credit_counter_tb \
    -f build.f -o credit_counter_sim > build.log 2>&1 \
    && ./obj_dir/credit_counter_sim > sim.log 2>&1 \
    || echo "Simulation failed (build or run error, see build.log)" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
